// ==== rtl/isaPkg.sv ====
`default_nettype none

package isaPkg;

	////////////////////////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		OP_ADD    = 5'b00000,
		OP_SUB    = 5'b00001,
		OP_OR     = 5'b00011,
		OP_AND    = 5'b00100,
		OP_SHFT   = 5'b00101,
		OP_LOAD   = 5'b01010,
		OP_STOR   = 5'b01011,
		OP_INPUT  = 5'b01100,
		OP_OUTPUT = 5'b01101,
		OP_NOP    = 5'b01111,
		OP_LDA    = 5'b10001,
		OP_STA    = 5'b10010,
		OP_LDB    = 5'b10011,
		OP_STB    = 5'b10100
	} opcodeT;

	typedef enum logic [2:0] {
		MODE_DIR = 3'b000, // Address in IR data
		MODE_IND = 3'b001, // Pointer in IR data
		MODE_IMM = 3'b010  // Operand is IR data
	} addrModeT;

	typedef struct packed {
		opcodeT   opcode;
		addrModeT mode;
	} addrViewT;

	typedef struct packed {
		opcodeT opcode;
		logic   rsvd;
		logic   dirRight; // 1 shifts right
		logic   fill;     // Bit shifted in
	} shiftViewT;

	typedef union packed {
		addrViewT  addr;
		shiftViewT shift;
	} instrWordT;

	////////////////////////////////////////////////////////////
	// Decoded instruction
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		CLS_NONE,   // Retired without steps
		CLS_ALU,
		CLS_LOAD,
		CLS_STORE,
		CLS_SHIFT,
		CLS_INPUT,
		CLS_OUTPUT
	} opClassT;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR,
		ALU_AND
	} aluOpT;

	typedef enum logic [1:0] {
		REG_NONE,
		REG_ACC,
		REG_A,
		REG_B
	} regSelT;

	localparam int shiftAmtW = 3;

	typedef struct packed {
		logic                 valid;
		opClassT              opClass;
		aluOpT                aluOp;
		regSelT               regSel;   // Target of a load, source of a store
		addrModeT             mode;
		logic                 shiftDir;
		logic                 shiftFill;
		logic [shiftAmtW-1:0] shiftAmt;
	} decodedT;

endpackage

`default_nettype wire

// ==== rtl/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	import isaPkg::*;

	////////////////////////////////////////////////////////////
	// Sequencer steps
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		STEP_IDLE,
		STEP_ADDR_IR,
		STEP_READ_PTR,
		STEP_ADDR_MDR,
		STEP_READ_OPND,
		STEP_EXECUTE,
		STEP_WRITE_SETUP,
		STEP_WRITE_MEM,
		STEP_WAIT_INPUT,   // Holds on inputRdy
		STEP_TAKE_INPUT,
		STEP_WAIT_OUTDEV,  // Holds on outDevRdy
		STEP_SEND_OUTPUT   // Holds on outRecv
	} stepT;

	////////////////////////////////////////////////////////////
	// Control word
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		MAR_NONE,
		MAR_IR,
		MAR_MDR
	} marSelT;

	typedef enum logic [1:0] {
		WSRC_ALU,
		WSRC_MDR,
		WSRC_SHIFTER,
		WSRC_INPORT
	} writeSrcT;

	typedef struct packed {
		marSelT   marSel;
		logic     memRead;
		logic     memWrite;
		logic     mdrLoad;
		aluOpT    aluOp;
		logic     opndFromIr; // ALU B input from IR data
		writeSrcT writeSrc;
		regSelT   regWrite;
		regSelT   storeSrc;
		logic     outLoad;
		logic     shiftDir;
		logic     shiftFill;
	} ctrlWordT;

	localparam ctrlWordT idleWord = '0;

	// Step plus the instruction it belongs to
	typedef struct packed {
		stepT    step;
		decodedT dec;
	} seqStageT;

endpackage

`default_nettype wire

// ==== rtl/instrDecode.sv ====
`default_nettype none

module instrDecode import isaPkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  instrWordT  instr,
	input  logic [7:0] irData,
	input  logic       stg0Valid,
	input  logic       seqIdle,
	output logic       stg1Ready,
	output decodedT    decoded
);

	logic    accept;
	logic    decValid;
	logic    modeOk;
	logic    storeModeOk;
	decodedT decNext;
	decodedT decHeld;

	assign stg1Ready   = seqIdle & ~decValid; // Nothing waiting for the sequencer
	assign accept      = stg0Valid & stg1Ready;
	assign modeOk      = instr.addr.mode inside {MODE_DIR, MODE_IND, MODE_IMM};
	assign storeModeOk = instr.addr.mode inside {MODE_DIR, MODE_IND};

	////////////////////////////////////////////////////////////
	// Opcode decode
	////////////////////////////////////////////////////////////

	always_comb begin
		decNext          = '0;
		decNext.mode     = instr.addr.mode;
		decNext.shiftAmt = irData[shiftAmtW-1:0];
		case (instr.addr.opcode)
			OP_ADD: decNext.opClass = CLS_ALU;
			OP_SUB: begin
				decNext.opClass = CLS_ALU;
				decNext.aluOp   = ALU_SUB;
			end
			OP_OR: begin
				decNext.opClass = CLS_ALU;
				decNext.aluOp   = ALU_OR;
			end
			OP_AND: begin
				decNext.opClass = CLS_ALU;
				decNext.aluOp   = ALU_AND;
			end
			OP_LOAD, OP_LDA, OP_LDB:  decNext.opClass = CLS_LOAD;
			OP_STOR, OP_STA, OP_STB:  decNext.opClass = CLS_STORE;
			OP_SHFT: begin
				decNext.opClass   = CLS_SHIFT;
				decNext.shiftDir  = instr.shift.dirRight; // Low bits read as flags
				decNext.shiftFill = instr.shift.fill;
			end
			OP_INPUT:  decNext.opClass = CLS_INPUT;
			OP_OUTPUT: decNext.opClass = CLS_OUTPUT;
			default:   decNext.opClass = CLS_NONE; // NOP and retired opcodes
		endcase

		case (instr.addr.opcode)
			OP_LDA, OP_STA: decNext.regSel = REG_A;
			OP_LDB, OP_STB: decNext.regSel = REG_B;
			default:        decNext.regSel = REG_ACC;
		endcase

		// Illegal modes retire with no step
		if ((decNext.opClass inside {CLS_ALU, CLS_LOAD}) && !modeOk)
			decNext.opClass = CLS_NONE;
		if ((decNext.opClass == CLS_STORE) && !storeModeOk)
			decNext.opClass = CLS_NONE;
	end

	////////////////////////////////////////////////////////////
	// Hold register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decValid <= 1'b0;
		end else begin
			decValid <= accept; // Single cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			decHeld <= decNext;
		end
	end

	always_comb begin
		decoded       = decHeld;
		decoded.valid = decValid;
	end

endmodule

`default_nettype wire

// ==== rtl/stepSequencer.sv ====
`default_nettype none

module stepSequencer import isaPkg::*, ctrlPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  decodedT  decoded,
	input  logic     inputRdy,
	input  logic     outDevRdy,
	input  logic     outRecv,
	output logic     seqIdle,
	output seqStageT stage
);

	stepT    step;
	stepT    stepNext;
	stepT    afterAddr;
	decodedT inFlight;
	logic    isStore;
	logic    isInd;

	assign seqIdle = (step == STEP_IDLE);
	assign isStore = (inFlight.opClass == CLS_STORE);
	assign isInd   = (inFlight.mode == MODE_IND);

	// Stores skip the operand read
	assign afterAddr = isStore ? STEP_WRITE_SETUP : STEP_READ_OPND;

	////////////////////////////////////////////////////////////
	// Next step
	////////////////////////////////////////////////////////////

	always_comb begin
		stepNext = step;
		case (step)
			STEP_IDLE: begin
				if (decoded.valid) begin
					case (decoded.opClass)
						CLS_ALU, CLS_LOAD: begin
							if (decoded.mode == MODE_IMM)
								stepNext = STEP_EXECUTE;
							else
								stepNext = STEP_ADDR_IR;
						end
						CLS_STORE:  stepNext = STEP_ADDR_IR;
						CLS_SHIFT:  stepNext = STEP_EXECUTE;
						CLS_INPUT:  stepNext = STEP_WAIT_INPUT;
						CLS_OUTPUT: stepNext = STEP_WAIT_OUTDEV;
						default:    stepNext = STEP_IDLE; // Retired without steps
					endcase
				end
			end
			STEP_ADDR_IR: begin
				if (isInd)
					stepNext = STEP_READ_PTR;
				else
					stepNext = afterAddr;
			end
			STEP_READ_PTR:    stepNext = STEP_ADDR_MDR;
			STEP_ADDR_MDR:    stepNext = afterAddr;
			STEP_READ_OPND:   stepNext = STEP_EXECUTE;
			STEP_WRITE_SETUP: stepNext = STEP_WRITE_MEM;
			STEP_WAIT_INPUT: begin
				if (inputRdy)
					stepNext = STEP_TAKE_INPUT;
			end
			STEP_WAIT_OUTDEV: begin
				if (outDevRdy)
					stepNext = STEP_SEND_OUTPUT;
			end
			STEP_SEND_OUTPUT: begin
				if (outRecv)
					stepNext = STEP_IDLE; // Device took the data
			end
			default: stepNext = STEP_IDLE; // Last step of every sequence
		endcase
	end

	////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			step <= STEP_IDLE;
		end else begin
			step <= stepNext;
		end
	end

	always_ff @(posedge clk) begin
		if (seqIdle && decoded.valid) begin
			inFlight <= decoded;
		end
	end

	assign stage = '{step: step, dec: inFlight};

endmodule

`default_nettype wire

// ==== rtl/ctrlEncoder.sv ====
`default_nettype none

module ctrlEncoder import isaPkg::*, ctrlPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  seqStageT             stage,
	output ctrlWordT             ctrl,
	output logic [shiftAmtW-1:0] numShift,
	output logic                 inputRecv
);

	ctrlWordT             wordNext;
	logic [shiftAmtW-1:0] shiftNext;
	logic                 immOpnd;
	logic                 shiftExec;

	assign immOpnd   = (stage.dec.mode == MODE_IMM);
	assign shiftExec = (stage.step == STEP_EXECUTE) && (stage.dec.opClass == CLS_SHIFT);
	assign shiftNext = shiftExec ? stage.dec.shiftAmt : '0;

	////////////////////////////////////////////////////////////
	// Word rules
	////////////////////////////////////////////////////////////

	always_comb begin
		wordNext = idleWord;
		case (stage.step)
			STEP_ADDR_IR:   wordNext.marSel  = MAR_IR;
			STEP_ADDR_MDR:  wordNext.marSel  = MAR_MDR;
			STEP_READ_PTR:  wordNext.memRead = 1'b1;
			STEP_READ_OPND: wordNext.memRead = 1'b1;
			STEP_EXECUTE: begin
				case (stage.dec.opClass)
					CLS_ALU: begin
						wordNext.aluOp      = stage.dec.aluOp;
						wordNext.writeSrc   = WSRC_ALU;
						wordNext.regWrite   = REG_ACC;
						wordNext.opndFromIr = immOpnd;
					end
					CLS_LOAD: begin
						wordNext.writeSrc   = WSRC_MDR;
						wordNext.regWrite   = stage.dec.regSel;
						wordNext.opndFromIr = immOpnd; // Immediate bypasses memory
					end
					CLS_SHIFT: begin
						wordNext.writeSrc  = WSRC_SHIFTER;
						wordNext.regWrite  = REG_ACC;
						wordNext.shiftDir  = stage.dec.shiftDir;
						wordNext.shiftFill = stage.dec.shiftFill;
					end
					default: wordNext = idleWord;
				endcase
			end
			STEP_WRITE_SETUP: begin
				wordNext.storeSrc = stage.dec.regSel; // Register onto the MDR
				wordNext.mdrLoad  = 1'b1;
			end
			STEP_WRITE_MEM: wordNext.memWrite = 1'b1;
			STEP_TAKE_INPUT: begin
				wordNext.writeSrc = WSRC_INPORT;
				wordNext.regWrite = REG_ACC;
			end
			STEP_SEND_OUTPUT: wordNext.outLoad = 1'b1;
			default: wordNext = idleWord; // Idle and device waits
		endcase
	end

	////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ctrl      <= idleWord;
			numShift  <= '0;
			inputRecv <= 1'b0;
		end else begin
			ctrl      <= wordNext;
			numShift  <= shiftNext;
			inputRecv <= (stage.step == STEP_TAKE_INPUT); // Aligned with the word
		end
	end

endmodule

`default_nettype wire

// ==== rtl/stage1Ctrl.sv ====
`default_nettype none

module stage1Ctrl import isaPkg::*, ctrlPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  instrWordT            instr,
	input  logic [7:0]           irData,
	input  logic                 stg0Valid,
	input  logic                 inputRdy,
	input  logic                 outDevRdy,
	input  logic                 outRecv,
	output logic                 stg1Ready,
	output ctrlWordT             ctrl,
	output logic [shiftAmtW-1:0] numShift,
	output logic                 inputRecv
);

	decodedT  decoded;
	logic     seqIdle;
	seqStageT stage;

	instrDecode uDecode (
		.clk       (clk),
		.rstN      (rstN),
		.instr     (instr),
		.irData    (irData),
		.stg0Valid (stg0Valid),
		.seqIdle   (seqIdle),
		.stg1Ready (stg1Ready),
		.decoded   (decoded)
	);

	stepSequencer uSequencer (
		.clk       (clk),
		.rstN      (rstN),
		.decoded   (decoded),
		.inputRdy  (inputRdy),
		.outDevRdy (outDevRdy),
		.outRecv   (outRecv),
		.seqIdle   (seqIdle),
		.stage     (stage)
	);

	ctrlEncoder uEncoder (
		.clk       (clk),
		.rstN      (rstN),
		.stage     (stage),
		.ctrl      (ctrl),
		.numShift  (numShift),
		.inputRecv (inputRecv)
	);

endmodule

`default_nettype wire

// ==== tb/ctrlModel.svh ====
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// One collected output cycle
typedef struct packed {
	ctrlWordT             word;
	logic [shiftAmtW-1:0] shamt;
	logic                 recv;
} obsT;

typedef obsT obsListT[$];

function automatic obsListT expectedList(input logic [7:0] instrBits, input logic [7:0] data);
	obsListT    lst;
	obsT        o;
	logic [4:0] op;
	logic [2:0] md;
	logic       isAlu;
	logic       isLoad;
	logic       isStore;
	regSelT     r;
	op      = instrBits[7:3];
	md      = instrBits[2:0];
	isAlu   = op inside {OP_ADD, OP_SUB, OP_OR, OP_AND};
	isLoad  = op inside {OP_LOAD, OP_LDA, OP_LDB};
	isStore = op inside {OP_STOR, OP_STA, OP_STB};
	r       = (op inside {OP_LDA, OP_STA}) ? REG_A : (op inside {OP_LDB, OP_STB}) ? REG_B : REG_ACC;
	o       = '0;
	if (((isAlu || isLoad) && md > 3'd2) || (isStore && md > 3'd1))
		return lst; // Illegal mode retires silently
	if ((isAlu || isLoad || isStore) && md != MODE_IMM) begin
		o.word.marSel = MAR_IR;
		lst.push_back(o);
		o.word = idleWord;
		if (md == MODE_IND) begin
			o.word.memRead = 1'b1;
			lst.push_back(o);
			o.word = idleWord;
			o.word.marSel = MAR_MDR;
			lst.push_back(o);
			o.word = idleWord;
		end
		if (!isStore) begin
			o.word.memRead = 1'b1; // Operand read
			lst.push_back(o);
			o.word = idleWord;
		end
	end
	if (isAlu) begin
		case (op)
			OP_SUB:  o.word.aluOp = ALU_SUB;
			OP_OR:   o.word.aluOp = ALU_OR;
			OP_AND:  o.word.aluOp = ALU_AND;
			default: o.word.aluOp = ALU_ADD;
		endcase
		o.word.writeSrc   = WSRC_ALU;
		o.word.regWrite   = REG_ACC;
		o.word.opndFromIr = (md == MODE_IMM);
		lst.push_back(o);
	end else if (isLoad) begin
		o.word.writeSrc   = WSRC_MDR;
		o.word.regWrite   = r;
		o.word.opndFromIr = (md == MODE_IMM);
		lst.push_back(o);
	end else if (isStore) begin
		o.word.storeSrc = r;
		o.word.mdrLoad  = 1'b1;
		lst.push_back(o);
		o.word = idleWord;
		o.word.memWrite = 1'b1;
		lst.push_back(o);
	end else if (op == OP_SHFT) begin
		o.word.writeSrc  = WSRC_SHIFTER;
		o.word.regWrite  = REG_ACC;
		o.word.shiftDir  = instrBits[1];
		o.word.shiftFill = instrBits[0];
		o.shamt          = data[shiftAmtW-1:0];
		lst.push_back(o);
	end else if (op == OP_INPUT) begin
		o.word.writeSrc = WSRC_INPORT;
		o.word.regWrite = REG_ACC;
		o.recv          = 1'b1;
		lst.push_back(o);
	end else if (op == OP_OUTPUT) begin
		o.word.outLoad = 1'b1;
		lst.push_back(o);
	end
	return lst;
endfunction

`endif

// ==== tb/stage1CtrlTb.sv ====
`default_nettype none

module stage1CtrlTb import isaPkg::*, ctrlPkg::*; ();

	logic                 clk;
	logic                 rstN;
	instrWordT            instr;
	logic [7:0]           irData;
	logic                 stg0Valid;
	logic                 inputRdy;
	logic                 outDevRdy;
	logic                 outRecv;
	logic                 stg1Ready;
	ctrlWordT             ctrl;
	logic [shiftAmtW-1:0] numShift;
	logic                 inputRecv;

	`include "ctrlModel.svh"

	obsListT    expQ;
	obsT        gotQ[$];
	string      testName = "reset";
	string      expName = "reset";
	logic       prevOutLoad = 1'b0;
	logic       recvSeen = 1'b0;
	logic       justAccepted = 1'b0;
	logic [4:0] opTable[$] = '{OP_ADD, OP_SUB, OP_OR, OP_AND, OP_LOAD, OP_LDA, OP_LDB,
		OP_STOR, OP_STA, OP_STB, OP_SHFT, OP_INPUT, OP_OUTPUT, OP_NOP, 5'b11000};

	stage1Ctrl dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Checks and waits
	////////////////////////////////////////////////////////////

	task automatic failNow(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [31:0] expV, input logic [31:0] actV);
		assert (expV === actV)
		else failNow($sformatf("ERROR %s expected %0h actual %0h", name, expV, actV));
	endtask

	task automatic compareCollected();
		checkEq({expName, " word count"}, 32'(expQ.size()), 32'(gotQ.size()));
		foreach (expQ[i])
			checkEq($sformatf("%s word %0d", expName, i), 32'(expQ[i]), 32'(gotQ[i]));
		expQ.delete();
		gotQ.delete();
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// sel 0 is stg1Ready, 1 is inputRecv, 2 is ctrl.outLoad
	task automatic awaitSignal(input int sel, input logic level, input string what);
		int   cycles;
		logic seen;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			seen = (sel == 0) ? stg1Ready : (sel == 1) ? inputRecv : ctrl.outLoad;
			if (cycles > 64)
				failNow({"Timed out waiting for ", what});
		end while (seen !== level);
		#1;
	endtask

	task automatic issueInstr(input logic [4:0] op, input logic [2:0] low, input string name);
		testName  = name;
		instr     = {op, low};
		irData    = 8'($urandom);
		stg0Valid = 1'b1; // Held until accepted
		awaitSignal(0, 1'b1, "stg1Ready");
		if (op == OP_INPUT || op == OP_OUTPUT) begin
			stg0Valid = 1'b0;
			idleCycles(int'($urandom % 4));
			if (op == OP_INPUT) begin
				inputRdy = 1'b1;
				awaitSignal(1, 1'b1, "inputRecv");
				inputRdy = 1'b0;
			end else begin
				outDevRdy = 1'b1;
				awaitSignal(2, 1'b1, "outLoad");
				outDevRdy = 1'b0;
				idleCycles(int'($urandom % 4));
				outRecv = 1'b1;
				idleCycles(1);
				outRecv = 1'b0;
				awaitSignal(2, 1'b0, "outLoad to drop");
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitor
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		obsT seen;
		if (rstN) begin
			seen = '{word: ctrl, shamt: numShift, recv: inputRecv};
			if (seen != '0 && !(ctrl.outLoad && prevOutLoad))
				gotQ.push_back(seen); // SEND_OUTPUT repeats until outRecv
			if (ctrl.outLoad && !prevOutLoad)
				recvSeen = 1'b0;
			if (outRecv)
				recvSeen = 1'b1;
			assert (!(prevOutLoad && !ctrl.outLoad && !recvSeen))
			else failNow("outLoad dropped before the device raised outRecv");
			prevOutLoad = ctrl.outLoad;
			if (justAccepted)
				checkEq({expName, " stg1Ready after accept"}, 32'd0, 32'(stg1Ready));
			justAccepted = stg0Valid && stg1Ready;
			if (justAccepted) begin
				compareCollected();
				expQ    = expectedList(instr, irData);
				expName = testName;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		int idx;
		void'($urandom(77611));
		rstN      = 1'b0;
		instr     = '0;
		irData    = '0;
		stg0Valid = 1'b0;
		inputRdy  = 1'b0;
		outDevRdy = 1'b0;
		outRecv   = 1'b0;
		repeat (3) @(posedge clk);
		#1 rstN = 1'b1;
		checkEq("reset stg1Ready", 32'd1, 32'(stg1Ready));
		checkEq("reset ctrl", 32'(idleWord), 32'(ctrl));
		checkEq("reset numShift", 32'd0, 32'(numShift));
		checkEq("reset inputRecv", 32'd0, 32'(inputRecv));
		for (int i = 0; i < 7; i++) // ALU ops and loads
			for (int m = 0; m < 3; m++)
				issueInstr(opTable[i], 3'(m), $sformatf("op %05b mode %0d", opTable[i], m));
		for (int i = 7; i < 10; i++)
			for (int m = 0; m < 2; m++)
				issueInstr(opTable[i], 3'(m), $sformatf("op %05b mode %0d", opTable[i], m));
		for (int m = 0; m < 4; m++)
			issueInstr(OP_SHFT, {1'($urandom), 2'(m)}, $sformatf("SHFT flags %0d", m));
		repeat (3) issueInstr(OP_INPUT, 3'($urandom), "INPUT");
		repeat (3) issueInstr(OP_OUTPUT, 3'($urandom), "OUTPUT");
		issueInstr(OP_NOP, 3'd0, "NOP");
		issueInstr(5'b11000, 3'd0, "dropped opcode");
		issueInstr(OP_STOR, MODE_IMM, "STOR immediate");
		repeat (40) begin
			idx = int'($urandom % 15);
			issueInstr(opTable[idx], 3'($urandom), $sformatf("random op %05b", opTable[idx]));
		end
		stg0Valid = 1'b0;
		awaitSignal(0, 1'b1, "final idle");
		idleCycles(3); // Last word drains out of the encoder
		compareCollected();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tb
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/instrDecode.sv
rtl/stepSequencer.sv
rtl/ctrlEncoder.sv
rtl/stage1Ctrl.sv
tb/stage1CtrlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --timing --assert -f tb.f --top-module stage1CtrlTb -o simTb; then
	echo "Verilator compile failed"
	exit 1
fi
simOut=$(./obj_dir/simTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi
if echo "$simOut" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
